//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = dcache_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Something failed" >> $(LOG)
	cat $(LOG)
	! grep -q "Something failed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/dcache.sv
`timescale 1ns/100ps

module dcache
   import dcache_geom_pkg::*;
(
   input logic CLK,
   input logic nRST,

   // processor side
   input logic halt,
   input logic dmemREN,
   input logic dmemWEN,
   input word_t dmemaddr,
   input word_t dmemstore,
   output logic dhit,
   output word_t dmemload,
   output logic flushed,

   // memory side
   output logic dREN,
   output logic dWEN,
   output word_t daddr,
   output word_t dstore,
   input word_t dload,
   input logic dwait
);

   // controller to storage link
   way_access_if acc_if ();

   dcache_ctrl u_ctrl (
      .CLK (CLK),
      .nRST (nRST),
      .halt (halt),
      .dmemREN (dmemREN),
      .dmemWEN (dmemWEN),
      .dmemaddr (dmemaddr),
      .dmemstore (dmemstore),
      .dhit (dhit),
      .dmemload (dmemload),
      .flushed (flushed),
      .dREN (dREN),
      .dWEN (dWEN),
      .daddr (daddr),
      .dstore (dstore),
      .dload (dload),
      .dwait (dwait),
      .acc (acc_if.ctrl)
   );

   dcache_ways u_ways (
      .CLK (CLK),
      .nRST (nRST),
      .acc (acc_if.ways)
   );

endmodule

//--- design/dcache_addr_pkg.sv
package dcache_addr_pkg;

   import dcache_geom_pkg::*;

   // one address word, seen as a raw word or as cache fields
   typedef union packed {
      word_t raw;
      struct packed {
         logic [tag_bits-1:0] tag;
         logic [set_bits-1:0] idx;
         // word within the two-word block
         logic wsel;
         logic [offs_bits-2:0] boff;
      } f;
   } dcache_addr_u;

endpackage

//--- design/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl
   import dcache_geom_pkg::*, dcache_addr_pkg::*;
(
   input logic CLK,
   input logic nRST,

   // processor side
   input logic halt,
   input logic dmemREN,
   input logic dmemWEN,
   input word_t dmemaddr,
   input word_t dmemstore,
   output logic dhit,
   output word_t dmemload,
   output logic flushed,

   // memory side
   output logic dREN,
   output logic dWEN,
   output word_t daddr,
   output word_t dstore,
   input word_t dload,
   input logic dwait,

   way_access_if.ctrl acc
);

   localparam logic [3:0] st_idle = 4'd0;
   localparam logic [3:0] st_wb1 = 4'd1;
   localparam logic [3:0] st_wb2 = 4'd2;
   localparam logic [3:0] st_read1 = 4'd3;
   localparam logic [3:0] st_read2 = 4'd4;
   localparam logic [3:0] st_dirty = 4'd5;
   localparam logic [3:0] st_flush1 = 4'd6;
   localparam logic [3:0] st_flush2 = 4'd7;
   localparam logic [3:0] st_halted = 4'd8;

   logic [3:0] state, next_state;
   logic [$clog2(flush_entries):0] cnt, next_cnt;
   logic wen_q, next_wen;

   logic req;
   logic scanning;
   logic filling;
   logic second_word;
   dcache_addr_u acc_addr;
   dcache_addr_u wb_addr;

   assign req = dmemREN | dmemWEN;
   assign scanning = (state == st_dirty) || (state == st_flush1) || (state == st_flush2);
   assign filling = (state == st_read1) || (state == st_read2);
   assign second_word = (state == st_wb2) || (state == st_read2) || (state == st_flush2);

   // processor address, with the word select forced during a fill
   always_comb
   begin
      acc_addr.raw = dmemaddr;
      if (filling)
      begin
         acc_addr.f.wsel = second_word;
         acc_addr.f.boff = '0;
      end
   end

   // victim or scanned block address for write-back
   always_comb
   begin
      wb_addr.f.tag = acc.victim_tag;
      wb_addr.f.idx = scanning ? cnt[set_bits-1:0] : acc_addr.f.idx;
      wb_addr.f.wsel = second_word;
      wb_addr.f.boff = '0;
   end

   assign acc.addr = acc_addr;
   assign acc.sel_way = (state == st_idle) ? acc.hit_way : acc.victim_way;
   assign acc.fill_word = dload;
   assign acc.store_word = dmemstore;
   assign acc.scan = scanning;
   assign acc.scan_set = cnt[set_bits-1:0];
   assign acc.scan_way = cnt[set_bits];

   assign dhit = (state == st_idle) && !halt && req && acc.hit;
   assign dmemload = acc.rd_word;
   assign flushed = (state == st_halted);

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         state <= st_idle;
         cnt <= '0;
         wen_q <= 1'b0;
      end
      else
      begin
         state <= next_state;
         cnt <= next_cnt;
         wen_q <= next_wen;
      end
   end

   always_comb
   begin
      next_state = state;
      next_cnt = cnt;
      next_wen = wen_q;
      case (state)
         st_idle:
         begin
            if (halt)
            begin
               next_cnt = '0;
               next_state = st_dirty;
            end
            else if (req && !acc.hit)
            begin
               // remember a store so the fill comes in dirty
               next_wen = dmemWEN;
               next_state = acc.victim_dv ? st_wb1 : st_read1;
            end
         end
         st_wb1:
            if (!dwait) next_state = st_wb2;
         st_wb2:
            if (!dwait) next_state = st_read1;
         st_read1:
            if (!dwait) next_state = st_read2;
         st_read2:
            if (!dwait) next_state = st_idle;
         st_dirty:
         begin
            if (cnt == flush_entries)
            begin
               next_state = st_halted;
            end
            else if (acc.victim_dv)
            begin
               next_state = st_flush1;
            end
            else
            begin
               next_cnt = cnt + 1'b1;
            end
         end
         st_flush1:
            if (!dwait) next_state = st_flush2;
         st_flush2:
         begin
            if (!dwait)
            begin
               next_cnt = cnt + 1'b1;
               next_state = st_dirty;
            end
         end
         st_halted:
            next_state = st_halted;
         default:
            next_state = st_idle;
      endcase
   end

   // storage write strobes
   always_comb
   begin
      acc.store_we = 1'b0;
      acc.fill_we = 1'b0;
      acc.tag_we = 1'b0;
      acc.valid_we = 1'b0;
      acc.dirty_we = 1'b0;
      acc.dirty_val = 1'b0;
      acc.lru_we = 1'b0;
      case (state)
         st_idle:
         begin
            if (dhit)
            begin
               acc.lru_we = 1'b1;
               // any write hit marks the block dirty
               if (dmemWEN)
               begin
                  acc.store_we = 1'b1;
                  acc.dirty_we = 1'b1;
                  acc.dirty_val = 1'b1;
               end
            end
         end
         st_wb2, st_flush2:
         begin
            acc.dirty_we = !dwait;
         end
         st_read1:
         begin
            acc.fill_we = !dwait;
         end
         st_read2:
         begin
            acc.fill_we = !dwait;
            acc.tag_we = !dwait;
            acc.valid_we = !dwait;
            acc.dirty_we = !dwait;
            acc.dirty_val = wen_q;
            acc.lru_we = !dwait;
         end
         default:
         begin
            acc.lru_we = 1'b0;
         end
      endcase
   end

   // memory port, held steady while dwait is high
   always_comb
   begin
      dREN = filling;
      dWEN = (state == st_wb1) || (state == st_wb2) || (state == st_flush1) ||
             (state == st_flush2);
      daddr = '0;
      dstore = '0;
      if (filling)
      begin
         daddr = acc_addr.raw;
      end
      else if (dWEN)
      begin
         daddr = wb_addr.raw;
         dstore = second_word ? acc.rd_word1 : acc.rd_word0;
      end
   end

endmodule

//--- design/dcache_geom_pkg.sv
package dcache_geom_pkg;

   // data word width
   localparam int word_w = 32;

   // two ways of eight sets
   localparam int set_bits = 3;
   localparam int num_sets = 1 << set_bits;
   localparam int num_ways = 2;

   // one bit of word select plus two bits of byte offset
   localparam int offs_bits = 3;

   // whatever is left of the word above index and offset
   localparam int tag_bits = word_w - set_bits - offs_bits;

   // halt walks every entry of every way once
   localparam int flush_entries = num_sets * num_ways;

   typedef logic [word_w-1:0] word_t;

endpackage

//--- design/dcache_ways.sv
`timescale 1ns/100ps

module dcache_ways
   import dcache_geom_pkg::*;
(
   input logic CLK,
   input logic nRST,
   way_access_if.ways acc
);

   // block storage, indexed [way][set]
   logic [tag_bits-1:0] tag_mem [num_ways][num_sets];
   word_t data_mem [num_ways][num_sets][2];
   logic valid [num_ways][num_sets];
   logic dirty [num_ways][num_sets];

   // one bit per set naming the way to replace next
   logic [num_sets-1:0] lru;

   logic [set_bits-1:0] idx;
   logic [set_bits-1:0] e_set;
   logic e_way;
   logic v_way;
   logic [num_ways-1:0] match;

   assign idx = acc.addr.f.idx;

   // tag compare against both ways of the indexed set
   always_comb
   begin
      for (int w = 0; w < num_ways; w++)
      begin
         match[w] = valid[w][idx] && (tag_mem[w][idx] == acc.addr.f.tag);
      end
   end

   assign acc.hit = |match;
   assign acc.hit_way = match[1];
   assign acc.victim_way = lru[idx];

   // the flush walk takes over the entry select
   assign e_set = acc.scan ? acc.scan_set : idx;
   assign e_way = acc.scan ? acc.scan_way : acc.sel_way;
   assign v_way = acc.scan ? acc.scan_way : lru[idx];

   // victim state, or the scanned entry during the walk
   assign acc.victim_dv = valid[v_way][e_set] & dirty[v_way][e_set];
   assign acc.victim_tag = tag_mem[v_way][e_set];

   // both words of the selected entry
   assign acc.rd_word0 = data_mem[e_way][e_set][0];
   assign acc.rd_word1 = data_mem[e_way][e_set][1];
   assign acc.rd_word = acc.addr.f.wsel ? acc.rd_word1 : acc.rd_word0;

   // tags and data
   always_ff @(posedge CLK)
   begin
      if (acc.store_we)
      begin
         data_mem[e_way][e_set][acc.addr.f.wsel] <= acc.store_word;
      end
      else if (acc.fill_we)
      begin
         data_mem[e_way][e_set][acc.addr.f.wsel] <= acc.fill_word;
      end
      if (acc.tag_we)
      begin
         tag_mem[e_way][e_set] <= acc.addr.f.tag;
      end
   end

   // valid, dirty and replacement state
   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         for (int w = 0; w < num_ways; w++)
         begin
            for (int s = 0; s < num_sets; s++)
            begin
               valid[w][s] <= 1'b0;
               dirty[w][s] <= 1'b0;
            end
         end
         lru <= '0;
      end
      else
      begin
         // blocks only become valid through a fill
         if (acc.valid_we)
         begin
            valid[e_way][e_set] <= 1'b1;
         end
         if (acc.dirty_we)
         begin
            dirty[e_way][e_set] <= acc.dirty_val;
         end
         // the way just used is the most recent, so point at the other one
         if (acc.lru_we)
         begin
            lru[e_set] <= ~e_way;
         end
      end
   end

endmodule

//--- design/way_access_if.sv
`timescale 1ns/100ps

interface way_access_if
   import dcache_geom_pkg::*, dcache_addr_pkg::*;
   ();

   // request side, driven by the controller
   dcache_addr_u addr;
   logic sel_way;
   word_t fill_word;
   word_t store_word;
   logic store_we;
   logic fill_we;
   logic tag_we;
   logic valid_we;
   logic dirty_we;
   logic dirty_val;
   logic lru_we;

   // flush walk entry select
   logic scan;
   logic [set_bits-1:0] scan_set;
   logic scan_way;

   // return side, driven by the way storage
   logic hit;
   logic hit_way;
   logic victim_way;
   logic victim_dv;
   logic [tag_bits-1:0] victim_tag;
   word_t rd_word;
   word_t rd_word0;
   word_t rd_word1;

   modport ctrl (
      output addr, sel_way, fill_word, store_word, store_we, fill_we, tag_we,
      output valid_we, dirty_we, dirty_val, lru_we, scan, scan_set, scan_way,
      input hit, hit_way, victim_way, victim_dv, victim_tag, rd_word, rd_word0, rd_word1
   );

   modport ways (
      input addr, sel_way, fill_word, store_word, store_we, fill_we, tag_we,
      input valid_we, dirty_we, dirty_val, lru_we, scan, scan_set, scan_way,
      output hit, hit_way, victim_way, victim_dv, victim_tag, rd_word, rd_word0, rd_word1
   );

endinterface

//--- sim/dcache_chk.sv
`timescale 1ns/100ps

module dcache_chk
   import dcache_geom_pkg::*;
(
   input logic CLK,
   input logic nRST,
   input logic dmemREN,
   input logic dmemWEN,
   input logic dhit,
   input logic flushed,
   input logic dREN,
   input logic dWEN,
   input word_t daddr,
   input word_t dstore,
   input logic dwait
);

   // one memory direction at a time
   a_one_dir: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
      else $error("dREN and dWEN high in the same cycle");

   // address and store data hold while the memory stalls
   a_hold: assert property (@(posedge CLK) disable iff (!nRST)
      ((dREN || dWEN) && dwait) |=> ($stable(daddr) && $stable(dstore)))
      else $error("daddr or dstore changed while dwait was high");

   a_quiet: assert property (@(posedge CLK) disable iff (!nRST)
      flushed |-> !(dREN || dWEN))
      else $error("memory request after flushed went high");

   a_hit_req: assert property (@(posedge CLK) disable iff (!nRST)
      dhit |-> (dmemREN || dmemWEN))
      else $error("dhit without a processor request");

endmodule

bind dcache dcache_chk u_chk (
   .CLK (CLK),
   .nRST (nRST),
   .dmemREN (dmemREN),
   .dmemWEN (dmemWEN),
   .dhit (dhit),
   .flushed (flushed),
   .dREN (dREN),
   .dWEN (dWEN),
   .daddr (daddr),
   .dstore (dstore),
   .dwait (dwait)
);

//--- sim/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb
   import dcache_geom_pkg::*;
();

   localparam int max_wait = 3;
   localparam int max_lat = max_wait + 1;
   localparam word_t fill_key = 32'h5a3c_0f00;
   localparam int n_tests = 22;
   localparam int reset_cycles = 8;
   localparam int cycle_limit = reset_cycles + n_tests * 4 * (max_lat + 2) + flush_entries * 8;

   localparam logic [1:0] op_rd = 2'd0;
   localparam logic [1:0] op_wr = 2'd1;
   localparam logic [1:0] op_halt = 2'd2;

   // expected memory traffic of an entry
   localparam logic [1:0] mem_none = 2'd0;
   localparam logic [1:0] mem_fill = 2'd1;
   localparam logic [1:0] mem_wb = 2'd2;

   logic CLK;
   logic nRST;
   logic halt;
   logic dmemREN;
   logic dmemWEN;
   logic dhit;
   logic flushed;
   logic dREN;
   logic dWEN;
   logic dwait;
   word_t dmemaddr;
   word_t dmemstore;
   word_t dmemload;
   word_t daddr;
   word_t dstore;
   word_t dload;

   // stimulus table
   logic [1:0] t_op [n_tests];
   word_t t_addr [n_tests];
   word_t t_data [n_tests];
   logic [1:0] t_mem [n_tests];

   word_t ref_mem [64];
   int seed = 35;
   int errors = 0;
   int checks = 0;
   int cycles = 0;
   logic entry_ok;

   dcache DUT (.*);

   ram_model #(.max_wait(max_wait), .fill_key(fill_key)) ram (.*);

   initial
   begin
      CLK = 1'b0;
      forever #4 CLK = ~CLK;
   end

   always @(posedge CLK)
   begin
      cycles <= cycles + 1;
      if (cycles == cycle_limit)
      begin
         $display("timeout after %0d cycles, the cache never answered", cycles);
         $display("Something failed");
         $finish;
      end
   end

   task automatic set_entry(input int i, input logic [1:0] op, input word_t addr,
                            input logic [1:0] mem);
      t_op[i] = op;
      t_addr[i] = addr;
      t_data[i] = $random(seed);
      t_mem[i] = mem;
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      checks++;
      assert (exp == act)
      else
      begin
         $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
         errors++;
         entry_ok = 1'b0;
      end
   endtask

   task automatic note_failure(input string msg);
      $display("%0t %s", $time, msg);
      errors++;
      entry_ok = 1'b0;
   endtask

   task automatic apply_entry(input int i);
      logic [5:0] w;
      word_t exp_load;
      word_t blk_addr;
      int n_rd;
      logic saw_rd;
      logic saw_wr;
      logic first_wr;
      w = t_addr[i][7:2];
      exp_load = ref_mem[w];
      blk_addr = {t_addr[i][31:3], 3'b000};
      n_rd = 0;
      saw_rd = 1'b0;
      saw_wr = 1'b0;
      first_wr = 1'b0;
      @(posedge CLK);
      #1;
      dmemaddr = t_addr[i];
      dmemstore = t_data[i];
      dmemREN = (t_op[i] == op_rd);
      dmemWEN = (t_op[i] == op_wr);
      @(negedge CLK);
      while (!dhit)
      begin
         if ((dREN || dWEN) && !saw_rd && !saw_wr)
            first_wr = dWEN;
         saw_rd = saw_rd | dREN;
         saw_wr = saw_wr | dWEN;
         // fill reads word 0 then word 1 of the requested block
         if (dREN && !dwait)
         begin
            check_word("daddr", blk_addr + word_t'(4 * n_rd), daddr);
            n_rd++;
         end
         // a write-back carries the latest value of that memory word
         if (dWEN && !dwait)
            check_word("dstore", ref_mem[daddr[7:2]], dstore);
         @(negedge CLK);
      end
      if (t_op[i] == op_rd)
         check_word("dmemload", exp_load, dmemload);
      else
         ref_mem[w] = t_data[i];
      checks++;
      case (t_mem[i])
         mem_none:
            assert (!saw_rd && !saw_wr)
            else note_failure("a hit was expected but the cache went to memory");
         mem_fill:
            assert (n_rd == 2 && !saw_wr)
            else note_failure("a clean fill was expected, the traffic differed");
         default:
            assert (saw_wr && first_wr && n_rd == 2)
            else note_failure("the dirty victim was not written back before the fill");
      endcase
      @(posedge CLK);
      #1;
      dmemREN = 1'b0;
      dmemWEN = 1'b0;
   endtask

   // halt, wait for the flush walk, then compare memory with the reference
   task automatic flush_and_compare();
      @(posedge CLK);
      #1;
      halt = 1'b1;
      @(negedge CLK);
      while (!flushed)
         @(negedge CLK);
      repeat (4)
      begin
         @(negedge CLK);
         checks++;
         assert (flushed)
         else note_failure("flushed dropped after the flush walk");
      end
      for (int a = 0; a < 64; a++)
         check_word($sformatf("ram.mem[%0d]", a), ref_mem[a], ram.mem[a]);
   endtask

   initial
   begin
      nRST = 1'b0;
      halt = 1'b0;
      dmemREN = 1'b0;
      dmemWEN = 1'b0;
      dmemaddr = '0;
      dmemstore = '0;
      for (int a = 0; a < 64; a++)
         ref_mem[a] = (a << 2) ^ fill_key;

      // set 1 takes blocks 0x008, 0x048 and 0x088 for the LRU case
      set_entry(0, op_rd, 32'h000, mem_fill);
      set_entry(1, op_rd, 32'h000, mem_none);
      set_entry(2, op_rd, 32'h004, mem_none);
      set_entry(3, op_wr, 32'h000, mem_none);
      set_entry(4, op_rd, 32'h000, mem_none);
      set_entry(5, op_rd, 32'h004, mem_none);
      set_entry(6, op_wr, 32'h010, mem_fill);
      set_entry(7, op_rd, 32'h010, mem_none);
      set_entry(8, op_rd, 32'h014, mem_none);
      set_entry(9, op_rd, 32'h008, mem_fill);
      set_entry(10, op_rd, 32'h048, mem_fill);
      set_entry(11, op_rd, 32'h008, mem_none);
      set_entry(12, op_rd, 32'h088, mem_fill);
      set_entry(13, op_rd, 32'h008, mem_none);
      set_entry(14, op_rd, 32'h048, mem_fill);
      // set 0 evictions with dirty victims
      set_entry(15, op_wr, 32'h040, mem_fill);
      set_entry(16, op_rd, 32'h080, mem_wb);
      set_entry(17, op_rd, 32'h000, mem_wb);
      set_entry(18, op_rd, 32'h040, mem_fill);
      set_entry(19, op_wr, 32'h018, mem_fill);
      set_entry(20, op_wr, 32'h0fc, mem_fill);
      set_entry(21, op_halt, 32'h000, mem_wb);

      repeat (reset_cycles) @(posedge CLK);
      #1;
      entry_ok = 1'b1;
      check_word("dhit", 32'd0, {31'd0, dhit});
      check_word("dREN", 32'd0, {31'd0, dREN});
      check_word("dWEN", 32'd0, {31'd0, dWEN});
      check_word("flushed", 32'd0, {31'd0, flushed});
      $display("reset state %s", entry_ok ? "passed" : "failed");
      nRST = 1'b1;

      for (int i = 0; i < n_tests; i++)
      begin
         entry_ok = 1'b1;
         if (t_op[i] == op_halt)
            flush_and_compare();
         else
            apply_entry(i);
         $display("entry %0d addr 0x%h %s", i, t_addr[i], entry_ok ? "passed" : "failed");
      end

      $display("%0d entries, %0d checks, %0d errors", n_tests, checks, errors);
      if (errors == 0)
      begin
         $display("Everything OK");
      end
      else
      begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

//--- sim/ram_model.sv
`timescale 1ns/100ps

module ram_model
   import dcache_geom_pkg::*;
#(
   parameter int max_wait = 3,
   parameter word_t fill_key = 32'h5a3c_0f00
)
(
   input logic CLK,
   input logic nRST,
   input logic dREN,
   input logic dWEN,
   input word_t daddr,
   input word_t dstore,
   output word_t dload,
   output logic dwait
);

   // 64 words cover byte addresses 0x00 to 0xff
   word_t mem [64];
   int wait_cnt;
   int lat;

   assign dload = mem[daddr[7:2]];

   // a transfer completes once the wait count reaches the current latency
   assign dwait = !((dREN || dWEN) && (wait_cnt == lat));

   always @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         wait_cnt <= 0;
         lat <= 1;
         for (int i = 0; i < 64; i++)
         begin
            mem[i] <= (i << 2) ^ fill_key;
         end
      end
      else if (dREN || dWEN)
      begin
         if (wait_cnt == lat)
         begin
            wait_cnt <= 0;
            // wait cycles rotate through 1 to max_wait
            lat <= (lat == max_wait) ? 1 : lat + 1;
            if (dWEN)
            begin
               mem[daddr[7:2]] <= dstore;
            end
         end
         else
         begin
            wait_cnt <= wait_cnt + 1;
         end
      end
   end

endmodule

//--- vlog.f
design/dcache_geom_pkg.sv
design/dcache_addr_pkg.sv
design/way_access_if.sv
design/dcache_ways.sv
design/dcache_ctrl.sv
design/dcache.sv
sim/ram_model.sv
sim/dcache_chk.sv
sim/dcache_tb.sv
